/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv32_mem
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Everything OK
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ns -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/rv32_branch_unit.sv */
`timescale 1ns/1ns

module rv32_branch_unit (
    input  logic                     predicted_taken,
    input  rv32_mem_pkg::branch_op_t op,
    input  logic [31:0]              result,
    output logic                     mispredicted
);
    import rv32_mem_pkg::*;

    logic result_zero;
    logic actual_taken;

    // execute already did the compare, only a zero test is left
    assign result_zero = (result == 32'd0);

    always_comb begin
        case (op)
            branch_never: begin
                actual_taken = 1'b0;
            end
            branch_zero: begin
                actual_taken = result_zero;
            end
            branch_nonzero: begin
                actual_taken = !result_zero;
            end
            branch_always: begin
                actual_taken = 1'b1;
            end
            default: begin
                actual_taken = 1'b0;
            end
        endcase
    end

    // predicted taken on a non-branch also counts
    assign mispredicted = (actual_taken != predicted_taken);

endmodule

/* design/rv32_data_ram.sv */
`timescale 1ns/1ns

module rv32_data_ram #(
    parameter int ADDR_BITS = 6
) (
    input  logic        clk,
    input  logic        data_read,
    input  logic        data_write,
    input  logic [3:0]  data_mask,
    input  logic [31:0] data_address,
    input  logic [31:0] data_write_value,
    output logic [31:0] data_read_value
);
    import rv32_mem_pkg::*;

    localparam int DEPTH = 1 << ADDR_BITS;

    mem_word_t mem [DEPTH];

    logic [ADDR_BITS-1:0] word_index;
    mem_word_t old_word;
    mem_word_t new_word;
    mem_word_t merged_word;

    // byte offset dropped, upper bits wrap
    assign word_index = data_address[ADDR_BITS+1:2];

    assign old_word        = mem[word_index];
    assign data_read_value = old_word.word; // async read

    assign new_word.word = data_write_value;

    always_comb begin
        merged_word = old_word;
        for (int i = 0; i < 4; i++) begin
            if (data_mask[i]) begin
                merged_word.bytes[i] = new_word.bytes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_write) begin
            mem[word_index] <= merged_word;
        end
    end

    // the stage issues at most one access per cycle
    assert property (@(posedge clk) !(data_read && data_write))
        else $error("data ram read and write in the same cycle");

endmodule

/* design/rv32_mem.sv */
`timescale 1ns/1ns

module rv32_mem (
    input  logic                     clk,
    input  logic                     reset,

    // hazard control
    input  logic                     stall,
    input  logic                     flush,

    // from execute
    input  logic                     valid,
    input  logic                     read,
    input  logic                     write,
    input  rv32_mem_pkg::mem_width_t width,
    input  logic                     zero_extend,
    input  rv32_mem_pkg::branch_op_t branch_op,
    input  logic                     branch_predicted_taken,
    input  logic [4:0]               rd,
    input  logic                     rd_write,
    input  logic [31:0]              result,
    input  logic [31:0]              rs2_value,

    // from data ram
    input  logic [31:0]              data_read_value,

    output logic                     branch_mispredicted,

    // to data ram
    output logic                     data_read,
    output logic                     data_write,
    output logic [3:0]               data_mask,
    output logic [31:0]              data_address,
    output logic [31:0]              data_write_value,

    // to write-back
    output logic                     wb_valid,
    output logic [4:0]               wb_rd,
    output logic                     wb_rd_write,
    output logic [31:0]              wb_rd_value
);
    import rv32_mem_pkg::*;

    logic      mispredicted;
    logic [3:0] write_mask;
    mem_word_t store_word;
    mem_word_t load_word;
    logic [15:0] half_lane;
    logic [7:0]  byte_lane;
    logic [31:0] load_value;

    // ========================================
    // branch resolution
    // ========================================

    rv32_branch_unit branch_unit (
        .predicted_taken (branch_predicted_taken),
        .op              (branch_op),
        .result          (result),
        .mispredicted    (mispredicted)
    );

    assign branch_mispredicted = mispredicted && !flush;

    // ========================================
    // store path
    // ========================================

    assign data_address = result;
    assign data_read    = read && valid;
    // one write per instruction, even across a stall
    assign data_write   = write && valid && !flush && !stall;

    always_comb begin
        store_word.word = rs2_value;
        write_mask      = 4'b0000;
        case (width)
            width_word: begin
                write_mask = 4'b1111;
            end
            width_half: begin
                store_word.halves[0] = rs2_value[15:0];
                store_word.halves[1] = rs2_value[15:0];
                write_mask = result[1] ? 4'b1100 : 4'b0011; // bit 0 ignored
            end
            width_byte: begin
                for (int i = 0; i < 4; i++) begin
                    store_word.bytes[i] = rs2_value[7:0];
                end
                write_mask = 4'b0001 << result[1:0];
            end
            default: begin
                write_mask = 4'b0000;
            end
        endcase
    end

    assign data_write_value = store_word.word;
    assign data_mask        = data_write ? write_mask : 4'b0000;

    // ========================================
    // load path
    // ========================================

    assign load_word.word = data_read_value;
    assign half_lane      = load_word.halves[result[1]];
    assign byte_lane      = load_word.bytes[result[1:0]];

    always_comb begin
        case (width)
            width_word: begin
                load_value = load_word.word;
            end
            width_half: begin
                load_value = {{16{!zero_extend && half_lane[15]}}, half_lane};
            end
            width_byte: begin
                load_value = {{24{!zero_extend && byte_lane[7]}}, byte_lane};
            end
            default: begin
                load_value = 32'd0;
            end
        endcase
    end

    // ========================================
    // write-back register
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid    <= 1'b0;
            wb_rd       <= 5'd0;
            wb_rd_write <= 1'b0;
            wb_rd_value <= 32'd0;
        end else if (!stall) begin
            wb_valid    <= valid && !flush;
            wb_rd       <= rd;
            wb_rd_write <= rd_write && !flush; // flushed op must not hit regfile
            wb_rd_value <= read ? load_value : result;
        end
    end

    // ========================================
    // checks
    // ========================================

    // a single op is a load or a store, never both
    assert property (@(posedge clk) disable iff (reset) valid |-> !(read && write))
        else $error("read and write both high");

    assert property (@(posedge clk) disable iff (reset)
        (valid && (read || write)) |-> (width inside {width_word, width_half, width_byte}))
        else $error("illegal access width");

    // a store with no lanes enabled would be silently lost in the ram
    assert property (@(posedge clk) disable iff (reset) data_write |-> (data_mask != 4'b0000))
        else $error("store with empty byte mask");

endmodule

/* design/rv32_mem_pkg.sv */
package rv32_mem_pkg;

    // ========================================
    // access width
    // ========================================

    // 2'b11 is not a legal width
    typedef enum logic [1:0] {
        width_word = 2'b00,
        width_half = 2'b01,
        width_byte = 2'b10
    } mem_width_t;

    // ========================================
    // branch condition
    // ========================================

    typedef enum logic [1:0] {
        branch_never   = 2'b00,
        branch_zero    = 2'b01, // taken on result == 0
        branch_nonzero = 2'b10, // taken on result != 0
        branch_always  = 2'b11
    } branch_op_t;

    // ========================================
    // memory word views
    // ========================================

    // lane 0 is the least significant byte (little endian)
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_t;

endpackage

/* design/rv32_mem_top.sv */
`timescale 1ns/1ns

module rv32_mem_top #(
    parameter int ADDR_BITS = 6
) (
    input  logic                     clk,
    input  logic                     reset,

    // hazard control
    input  logic                     stall,
    input  logic                     flush,

    // executed instruction
    input  logic                     valid,
    input  logic                     read,
    input  logic                     write,
    input  rv32_mem_pkg::mem_width_t width,
    input  logic                     zero_extend,
    input  rv32_mem_pkg::branch_op_t branch_op,
    input  logic                     branch_predicted_taken,
    input  logic [4:0]               rd,
    input  logic                     rd_write,
    input  logic [31:0]              result,
    input  logic [31:0]              rs2_value,

    output logic                     branch_mispredicted,

    // write-back
    output logic                     wb_valid,
    output logic [4:0]               wb_rd,
    output logic                     wb_rd_write,
    output logic [31:0]              wb_rd_value
);

    // ========================================
    // data bus between stage and ram
    // ========================================

    logic        data_read;
    logic        data_write;
    logic [3:0]  data_mask;
    logic [31:0] data_address;
    logic [31:0] data_write_value;
    logic [31:0] data_read_value;

    rv32_mem mem_stage (
        .clk                    (clk),
        .reset                  (reset),
        .stall                  (stall),
        .flush                  (flush),
        .valid                  (valid),
        .read                   (read),
        .write                  (write),
        .width                  (width),
        .zero_extend            (zero_extend),
        .branch_op              (branch_op),
        .branch_predicted_taken (branch_predicted_taken),
        .rd                     (rd),
        .rd_write               (rd_write),
        .result                 (result),
        .rs2_value              (rs2_value),
        .data_read_value        (data_read_value),
        .branch_mispredicted    (branch_mispredicted),
        .data_read              (data_read),
        .data_write             (data_write),
        .data_mask              (data_mask),
        .data_address           (data_address),
        .data_write_value       (data_write_value),
        .wb_valid               (wb_valid),
        .wb_rd                  (wb_rd),
        .wb_rd_write            (wb_rd_write),
        .wb_rd_value            (wb_rd_value)
    );

    // ========================================
    // data memory
    // ========================================

    rv32_data_ram #(
        .ADDR_BITS (ADDR_BITS)
    ) data_ram (
        .clk              (clk),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_mask        (data_mask),
        .data_address     (data_address),
        .data_write_value (data_write_value),
        .data_read_value  (data_read_value)
    );

endmodule

/* files.f */
design/rv32_mem_pkg.sv
design/rv32_branch_unit.sv
design/rv32_mem.sv
design/rv32_data_ram.sv
design/rv32_mem_top.sv
tests/tb_clock.sv
tests/tb_rv32_mem.sv

/* tests/mem_stim.txt */
// test op width zext address wdata bop pred stall flush rd exp_wb_value exp_mispredict
// op: 0 alu, 1 store, 2 load, 3 branch; width: 0 word, 1 half, 2 byte
1 1 0 0 00000010 deadbeef 0 0 0 0 00 00000010 0
1 2 0 0 00000010 00000000 0 0 0 0 05 deadbeef 0
1 1 0 0 00000024 12345678 0 0 0 0 00 00000024 0
1 2 0 0 00000124 00000000 0 0 0 0 1f 12345678 0
1 2 0 0 00000010 00000000 0 0 0 0 01 deadbeef 0
2 1 0 0 00000020 00000000 0 0 0 0 00 00000020 0
2 1 2 0 00000021 000000ab 0 0 0 0 00 00000021 0
2 1 1 0 00000022 00008001 0 0 0 0 00 00000022 0
2 1 2 0 00000020 ffffff7f 0 0 0 0 00 00000020 0
2 2 0 0 00000020 00000000 0 0 0 0 02 8001ab7f 0
2 2 2 0 00000020 00000000 0 0 0 0 03 0000007f 0
2 2 2 0 00000021 00000000 0 0 0 0 03 ffffffab 0
2 2 2 1 00000021 00000000 0 0 0 0 03 000000ab 0
2 2 2 0 00000022 00000000 0 0 0 0 03 00000001 0
2 2 2 0 00000023 00000000 0 0 0 0 03 ffffff80 0
2 2 2 1 00000023 00000000 0 0 0 0 03 00000080 0
2 2 1 0 00000020 00000000 0 0 0 0 04 ffffab7f 0
2 2 1 1 00000020 00000000 0 0 0 0 04 0000ab7f 0
2 2 1 0 00000023 00000000 0 0 0 0 04 ffff8001 0
2 2 1 1 00000022 00000000 0 0 0 0 04 00008001 0
2 1 1 0 00000020 ffff1234 0 0 0 0 00 00000020 0
2 1 2 0 00000023 1234565a 0 0 0 0 00 00000023 0
2 2 0 0 00000020 00000000 0 0 0 0 02 5a011234 0
3 0 0 0 cafef00d 00000000 0 0 0 0 03 cafef00d 0
3 0 0 0 00000000 ffffffff 0 0 0 0 01 00000000 0
4 3 0 0 00000000 00000000 0 0 0 0 00 00000000 0
4 3 0 0 00000000 00000000 0 1 0 0 00 00000000 1
4 3 0 0 00000005 00000000 0 0 0 0 00 00000005 0
4 3 0 0 00000005 00000000 0 1 0 0 00 00000005 1
4 3 0 0 00000000 00000000 1 0 0 0 00 00000000 1
4 3 0 0 00000000 00000000 1 1 0 0 00 00000000 0
4 3 0 0 80000000 00000000 1 0 0 0 00 80000000 0
4 3 0 0 80000000 00000000 1 1 0 0 00 80000000 1
4 3 0 0 00000000 00000000 2 0 0 0 00 00000000 0
4 3 0 0 00000000 00000000 2 1 0 0 00 00000000 1
4 3 0 0 00000005 00000000 2 0 0 0 00 00000005 1
4 3 0 0 00000005 00000000 2 1 0 0 00 00000005 0
4 3 0 0 00000000 00000000 3 0 0 0 00 00000000 1
4 3 0 0 00000000 00000000 3 1 0 0 00 00000000 0
4 3 0 0 80000000 00000000 3 0 0 0 00 80000000 1
4 3 0 0 80000000 00000000 3 1 0 0 00 80000000 0
4 3 0 0 00000000 00000000 3 0 0 1 00 00000000 0
4 3 0 0 00000000 00000000 1 0 0 1 00 00000000 0
5 1 0 0 00000030 11111111 0 0 0 0 00 00000030 0
5 1 0 0 00000030 22222222 0 0 0 1 00 00000030 0
5 2 0 0 00000030 00000000 0 0 0 0 06 11111111 0
5 2 0 0 00000010 00000000 0 0 0 1 07 deadbeef 0
5 0 0 0 a5a5a5a5 00000000 0 0 0 0 04 a5a5a5a5 0
5 1 0 0 00000030 33333333 0 0 1 0 00 a5a5a5a5 0
5 0 0 0 00000099 00000000 0 0 1 0 09 a5a5a5a5 0
5 2 0 0 00000030 00000000 0 0 0 0 08 11111111 0
// end of vectors
0 0 0 0 00000000 00000000 0 0 0 0 00 00000000 0

/* tests/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0; // released on a rising edge
    end

endmodule

/* tests/tb_rv32_mem.sv */
`timescale 1ns/1ns

module tb_rv32_mem;
    import rv32_mem_pkg::*;

    localparam string STIM_FILE     = "tests/mem_stim.txt";
    localparam int    FIELDS        = 13;
    localparam int    MAX_VECTORS   = 64;
    localparam int    RESET_TIMEOUT = 20;

    // columns of one vector
    localparam int COL_TEST  = 0;
    localparam int COL_OP    = 1;
    localparam int COL_WIDTH = 2;
    localparam int COL_ZEXT  = 3;
    localparam int COL_ADDR  = 4;
    localparam int COL_WDATA = 5;
    localparam int COL_BOP   = 6;
    localparam int COL_PRED  = 7;
    localparam int COL_STALL = 8;
    localparam int COL_FLUSH = 9;
    localparam int COL_RD    = 10;
    localparam int COL_VALUE = 11;
    localparam int COL_MIS   = 12;

    localparam int OP_ALU    = 0;
    localparam int OP_STORE  = 1;
    localparam int OP_LOAD   = 2;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    logic        valid;
    logic        read;
    logic        write;
    mem_width_t  width;
    logic        zero_extend;
    branch_op_t  branch_op;
    logic        branch_predicted_taken;
    logic [4:0]  rd;
    logic        rd_write;
    logic [31:0] result;
    logic [31:0] rs2_value;
    logic        branch_mispredicted;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic        wb_rd_write;
    logic [31:0] wb_rd_value;

    logic [31:0] stim [0:FIELDS*MAX_VECTORS-1];

    // expected write-back state after the last accepted vector
    logic        exp_valid;
    logic        exp_rd_write;
    logic [4:0]  exp_rd;
    logic [31:0] exp_value;
    logic        exp_known; // value and rd are undefined after a flush
    int          exp_test;
    int          exp_vector;

    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          vector_count;
    logic        reset_released;

    tb_clock clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    rv32_mem_top #(
        .ADDR_BITS (6)
    ) uut (
        .clk                    (clk),
        .reset                  (reset),
        .stall                  (stall),
        .flush                  (flush),
        .valid                  (valid),
        .read                   (read),
        .write                  (write),
        .width                  (width),
        .zero_extend            (zero_extend),
        .branch_op              (branch_op),
        .branch_predicted_taken (branch_predicted_taken),
        .rd                     (rd),
        .rd_write               (rd_write),
        .result                 (result),
        .rs2_value              (rs2_value),
        .branch_mispredicted    (branch_mispredicted),
        .wb_valid               (wb_valid),
        .wb_rd                  (wb_rd),
        .wb_rd_write            (wb_rd_write),
        .wb_rd_value            (wb_rd_value)
    );

    // ========================================
    // helpers
    // ========================================

    function automatic logic [31:0] stim_field(input int v, input int col);
        return stim[v * FIELDS + col];
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got %h, expected %h",
                     $time, what, actual, expected);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s passed", name);
        end else begin
            $display("%s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic drive_idle();
        stall                  <= 1'b0;
        flush                  <= 1'b0;
        valid                  <= 1'b0;
        read                   <= 1'b0;
        write                  <= 1'b0;
        width                  <= width_word;
        zero_extend            <= 1'b0;
        branch_op              <= branch_never;
        branch_predicted_taken <= 1'b0;
        rd                     <= 5'd0;
        rd_write               <= 1'b0;
        result                 <= 32'd0;
        rs2_value              <= 32'd0;
    endtask

    // nonzero write-back inputs while reset is high
    task automatic drive_reset_inputs();
        drive_idle();
        valid    <= 1'b1;
        rd       <= 5'h1f;
        rd_write <= 1'b1;
        result   <= 32'hffff_ffff;
    endtask

    task automatic drive_vector(input int v);
        logic [31:0] op;
        logic [31:0] w;
        logic [31:0] b;
        op = stim_field(v, COL_OP);
        w  = stim_field(v, COL_WIDTH);
        b  = stim_field(v, COL_BOP);
        stall                  <= stim_field(v, COL_STALL) != 32'd0;
        flush                  <= stim_field(v, COL_FLUSH) != 32'd0;
        valid                  <= 1'b1;
        read                   <= (op == OP_LOAD);
        write                  <= (op == OP_STORE);
        width                  <= mem_width_t'(w[1:0]);
        zero_extend            <= stim_field(v, COL_ZEXT) != 32'd0;
        branch_op              <= branch_op_t'(b[1:0]);
        branch_predicted_taken <= stim_field(v, COL_PRED) != 32'd0;
        rd                     <= 5'(stim_field(v, COL_RD));
        rd_write               <= (op == OP_ALU) || (op == OP_LOAD);
        result                 <= stim_field(v, COL_ADDR);
        rs2_value              <= stim_field(v, COL_WDATA);
    endtask

    // write-back register model, holds on stall
    task automatic update_expected(input int v);
        logic [31:0] op;
        logic        flushed;
        op      = stim_field(v, COL_OP);
        flushed = stim_field(v, COL_FLUSH) != 32'd0;
        exp_test   = stim_field(v, COL_TEST);
        exp_vector = v;
        exp_value  = stim_field(v, COL_VALUE);
        if (stim_field(v, COL_STALL) == 32'd0) begin
            exp_valid    = !flushed;
            exp_rd_write = !flushed && (op == OP_ALU || op == OP_LOAD);
            exp_rd       = 5'(stim_field(v, COL_RD));
            exp_known    = !flushed;
        end
    endtask

    task automatic check_writeback();
        string tag;
        tag = $sformatf("test %0d vector %0d", exp_test, exp_vector);
        check_value(32'(wb_valid), 32'(exp_valid), {tag, " wb_valid"});
        check_value(32'(wb_rd_write), 32'(exp_rd_write), {tag, " wb_rd_write"});
        if (exp_known) begin
            check_value(32'(wb_rd), 32'(exp_rd), {tag, " wb_rd"});
            check_value(wb_rd_value, exp_value, {tag, " wb_rd_value"});
        end
    endtask

    task automatic count_vectors();
        vector_count = 0;
        // a test number of zero ends the list
        while (vector_count < MAX_VECTORS && stim_field(vector_count, COL_TEST) != 32'd0
               && !$isunknown(stim_field(vector_count, COL_TEST))) begin
            vector_count++;
        end
        if (vector_count == 0) begin
            $display("no test vectors could be read from %s", STIM_FILE);
            error_count++;
        end
    endtask

    // returns on the falling edge right after the last reset edge
    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        @(posedge clk);
        @(negedge clk);
        while (reset && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        released = !reset;
    endtask

    task automatic check_reset_state();
        check_value(32'(wb_valid), 32'd0, "wb_valid after reset");
        check_value(32'(wb_rd_write), 32'd0, "wb_rd_write after reset");
        check_value(32'(wb_rd), 32'd0, "wb_rd after reset");
        check_value(wb_rd_value, 32'd0, "wb_rd_value after reset");
        report_test("reset test");
        @(posedge clk);
        drive_idle();
    endtask

    // ========================================
    // vector loop
    // ========================================

    // drive on the rising edge, look at outputs on the falling edge
    task automatic run_vectors();
        int v;
        for (v = 0; v < vector_count; v++) begin
            @(posedge clk);
            drive_vector(v);
            @(negedge clk);
            check_writeback(); // previous vector, one edge later
            if (v > 0 && stim_field(v, COL_TEST) != stim_field(v - 1, COL_TEST)) begin
                report_test($sformatf("test %0d", stim_field(v - 1, COL_TEST)));
            end
            check_value(32'(branch_mispredicted), stim_field(v, COL_MIS),
                        $sformatf("test %0d vector %0d branch_mispredicted",
                                  stim_field(v, COL_TEST), v));
            update_expected(v);
        end
        if (vector_count > 0) begin
            @(posedge clk);
            drive_idle();
            @(negedge clk);
            check_writeback();
            report_test($sformatf("test %0d", stim_field(vector_count - 1, COL_TEST)));
        end
    endtask

    initial begin
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_valid    = 1'b0;
        exp_rd_write = 1'b0;
        exp_rd       = 5'd0;
        exp_value    = 32'd0;
        exp_known    = 1'b1;
        exp_test     = 0;
        exp_vector   = 0;
        drive_reset_inputs();
        $readmemh(STIM_FILE, stim);
        count_vectors();
        wait_reset_release(reset_released);
        if (!reset_released) begin
            $display("reset was still high after %0d clock cycles", RESET_TIMEOUT);
            $display("Something failed");
            $finish;
        end else begin
            check_reset_state();
            run_vectors();
            $display("%0d tests run, %0d failed, %0d checks failed",
                     tests_run, tests_failed, error_count);
            if (error_count == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule
